// File: Bender.yml
package:
  name: tinker

sources:
  - hdl/tinker_pkg.sv
  - hdl/tinker_regfile.sv
  - hdl/tinker_memory.sv
  - hdl/tinker_fetch.sv
  - hdl/tinker_decode.sv
  - hdl/tinker_execute.sv
  - hdl/tinker_writeback.sv
  - hdl/tinker_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/clock_gen.sv
      - tb/tinker_assertions.sv
      - tb/tinker_tb.sv

// File: hdl/tinker_core.sv
`timescale 1ns/100ps

module tinker_core (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        load_we,
    input  tinker_pkg::addr_t           load_addr,
    input  logic [tinker_pkg::ILEN-1:0] load_word,
    input  tinker_pkg::addr_t           peek_addr,
    output logic [tinker_pkg::XLEN-1:0] peek_data,
    output logic                        hlt
);
    import tinker_pkg::*;

    logic            stall, redirect, halt_seen, running;
    addr_t           redirect_pc, fetch_addr;
    logic [ILEN-1:0] fetch_word;
    ifid_t           ifid;
    idex_t           idex;
    exmem_t          exmem;
    reg_idx_t        rf_rd_addr, rf_rs_addr, rf_rt_addr;
    logic [XLEN-1:0] rf_rd_val, rf_rs_val, rf_rt_val;
    reg_idx_t        wb_dest;
    logic [XLEN-1:0] wb_data, load_data;
    logic            wb_we;

    tinker_fetch u_fetch (
        .clk, .reset, .start, .stall, .redirect, .redirect_pc, .halt_seen,
        .fetch_addr, .fetch_word, .running, .ifid
    );

    tinker_decode u_decode (
        .clk, .reset, .ifid, .rf_rd_addr, .rf_rs_addr, .rf_rt_addr,
        .rf_rd_val, .rf_rs_val, .rf_rt_val, .exmem, .stall, .redirect,
        .redirect_pc, .halt_seen, .idex
    );

    tinker_execute u_execute (
        .clk, .reset, .idex, .wb_dest, .wb_data, .wb_we, .exmem
    );

    // mem stage is the memory data port fed from ex/mem
    tinker_memory u_memory (
        .clk, .fetch_addr, .fetch_word,
        .data_addr  (exmem.alu_result[31:0]),
        .data_we    (exmem.ctrl.mem_write),
        .store_data (exmem.store_data),
        .load_data, .load_we, .load_addr, .load_word, .running,
        .peek_addr, .peek_data
    );

    tinker_writeback u_writeback (
        .clk, .reset, .start, .exmem, .load_data, .wb_dest, .wb_data, .wb_we, .hlt
    );

    tinker_regfile u_regfile (
        .clk, .reset,
        .we      (wb_we),
        .wr_addr (wb_dest),
        .wr_data (wb_data),
        .rd_addr (rf_rd_addr),
        .rs_addr (rf_rs_addr),
        .rt_addr (rf_rt_addr),
        .rd_val  (rf_rd_val),
        .rs_val  (rf_rs_val),
        .rt_val  (rf_rt_val)
    );

endmodule

// File: hdl/tinker_decode.sv
`timescale 1ns/100ps

module tinker_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  tinker_pkg::ifid_t           ifid,
    output tinker_pkg::reg_idx_t        rf_rd_addr,
    output tinker_pkg::reg_idx_t        rf_rs_addr,
    output tinker_pkg::reg_idx_t        rf_rt_addr,
    input  logic [tinker_pkg::XLEN-1:0] rf_rd_val,
    input  logic [tinker_pkg::XLEN-1:0] rf_rs_val,
    input  logic [tinker_pkg::XLEN-1:0] rf_rt_val,
    input  tinker_pkg::exmem_t          exmem,
    output logic                        stall,
    output logic                        redirect,
    output tinker_pkg::addr_t           redirect_pc,
    output logic                        halt_seen,
    output tinker_pkg::idex_t           idex
);
    import tinker_pkg::*;

    opcode_t     opcode;
    reg_idx_t    rd, rs, rt;
    logic [11:0] lit;
    ctrl_t       ctrl;
    logic        taken;
    logic        load_use;
    logic        branch_haz;

    assign opcode = opcode_t'(ifid.instr[31:27]);
    assign rd     = ifid.instr[26:22];
    assign rs     = ifid.instr[21:17];
    assign rt     = ifid.instr[16:12];
    assign lit    = ifid.instr[11:0];

    assign rf_rd_addr = rd;
    assign rf_rs_addr = rs;
    assign rf_rt_addr = rt;

    // true when the decoded instruction may read register r
    function automatic logic reads_reg(reg_idx_t r);
        return r == rs || r == rt ||
               ((ctrl.uses_imm_base || ctrl.is_branch) && r == rd);
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTL, OP_MOV_RR:
                ctrl.reg_write = 1'b1;
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_RL: begin
                ctrl.reg_write     = 1'b1;
                ctrl.uses_imm_base = 1'b1; // rd op L
            end
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_write     = 1'b1;
                ctrl.uses_imm_base = 1'b1; // address base is rd
            end
            OP_BR, OP_BRR_RD, OP_BRR_L, OP_BRNZ, OP_BRGT:
                ctrl.is_branch = 1'b1;
            OP_HALT:
                ctrl.halt = 1'b1;
            default: ; // unknown opcode acts as a bubble
        endcase
    end

    // branches resolve here on register file values
    always_comb begin
        taken       = 1'b0;
        redirect_pc = rf_rd_val[31:0];
        case (opcode)
            OP_BR:     taken = 1'b1;
            OP_BRR_RD: begin
                taken       = 1'b1;
                redirect_pc = ifid.pc + rf_rd_val[31:0];
            end
            OP_BRR_L: begin
                taken       = 1'b1;
                redirect_pc = ifid.pc + {{20{lit[11]}}, lit};
            end
            OP_BRNZ:   taken = (rf_rs_val != '0);
            OP_BRGT:   taken = ($signed(rf_rs_val) > $signed(rf_rt_val));
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        // load result not ready until it leaves mem
        load_use   = idex.ctrl.mem_read && reads_reg(idex.rd);
        // branch operands must already sit in the regfile or mem/wb
        branch_haz = ctrl.is_branch &&
                     ((idex.ctrl.reg_write && reads_reg(idex.rd)) ||
                      (exmem.ctrl.reg_write && reads_reg(exmem.dest)));
        stall      = load_use || branch_haz;
        redirect   = taken && !stall;
        halt_seen  = ctrl.halt && !stall;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall) begin
            idex <= '0; // bubble
        end else begin
            idex <= '{ctrl: ctrl, opcode: opcode, rd: rd, rs: rs, rt: rt, lit: lit,
                      pc: ifid.pc, rd_val: rf_rd_val, rs_val: rf_rs_val,
                      rt_val: rf_rt_val};
        end
    end

endmodule

// File: hdl/tinker_execute.sv
`timescale 1ns/100ps

module tinker_execute (
    input  logic                        clk,
    input  logic                        reset,
    input  tinker_pkg::idex_t           idex,
    input  tinker_pkg::reg_idx_t        wb_dest,
    input  logic [tinker_pkg::XLEN-1:0] wb_data,
    input  logic                        wb_we,
    output tinker_pkg::exmem_t          exmem
);
    import tinker_pkg::*;

    fwd_sel_t        sel_rd, sel_rs, sel_rt;
    logic [XLEN-1:0] rd_v, rs_v, rt_v; // forwarded operands
    logic [XLEN-1:0] lit_sext, lit_zext;
    logic [XLEN-1:0] alu_out;

    // youngest writer wins, ex/mem before mem/wb
    function automatic fwd_sel_t pick(reg_idx_t r);
        if (exmem.ctrl.reg_write && exmem.dest == r)
            return FWD_EXMEM;
        if (wb_we && wb_dest == r)
            return FWD_MEMWB;
        return FWD_RF;
    endfunction

    function automatic logic [XLEN-1:0] operand(fwd_sel_t sel, logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_EXMEM: return exmem.alu_result;
            FWD_MEMWB: return wb_data;
            default:   return rf_val;
        endcase
    endfunction

    always_comb begin
        sel_rd = pick(idex.rd);
        sel_rs = pick(idex.rs);
        sel_rt = pick(idex.rt);
        rd_v   = operand(sel_rd, idex.rd_val);
        rs_v   = operand(sel_rs, idex.rs_val);
        rt_v   = operand(sel_rt, idex.rt_val);
    end

    assign lit_sext = {{(XLEN-12){idex.lit[11]}}, idex.lit}; // addresses
    assign lit_zext = {{(XLEN-12){1'b0}}, idex.lit};         // immediates

    always_comb begin
        case (idex.opcode)
            OP_ADD:    alu_out = rs_v + rt_v;
            OP_ADDI:   alu_out = rd_v + lit_zext;
            OP_SUB:    alu_out = rs_v - rt_v;
            OP_SUBI:   alu_out = rd_v - lit_zext;
            OP_MUL:    alu_out = rs_v * rt_v;
            OP_AND:    alu_out = rs_v & rt_v;
            OP_OR:     alu_out = rs_v | rt_v;
            OP_XOR:    alu_out = rs_v ^ rt_v;
            OP_NOT:    alu_out = ~rs_v;
            OP_SHFTR:  alu_out = rs_v >> rt_v;
            OP_SHFTRI: alu_out = rd_v >> lit_zext;
            OP_SHFTL:  alu_out = rs_v << rt_v;
            OP_SHFTLI: alu_out = rd_v << lit_zext;
            OP_MOV_RR: alu_out = rs_v;
            OP_MOV_RL: alu_out = {rd_v[XLEN-1:12], idex.lit}; // upper bits kept
            OP_LOAD:   alu_out = rs_v + lit_sext;
            OP_STORE:  alu_out = rd_v + lit_sext;
            default:   alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem <= '{ctrl: idex.ctrl, alu_result: alu_out,
                       store_data: rs_v, dest: idex.rd}; // store data is rs
        end
    end

endmodule

// File: hdl/tinker_fetch.sv
`timescale 1ns/100ps

module tinker_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        stall,
    input  logic                        redirect,
    input  tinker_pkg::addr_t           redirect_pc,
    input  logic                        halt_seen,
    output tinker_pkg::addr_t           fetch_addr,
    input  logic [tinker_pkg::ILEN-1:0] fetch_word,
    output logic                        running,
    output tinker_pkg::ifid_t           ifid
);
    import tinker_pkg::*;

    addr_t      pc;
    logic       fetching; // pc advancing
    logic [2:0] drain;    // halt still moving through ex, mem, wb

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= PC_RESET_ADDR;
            fetching <= 1'b0;
            drain    <= '0;
            ifid     <= '{pc: '0, instr: NOP_WORD};
        end else if (start) begin
            pc       <= PC_RESET_ADDR; // first fetch next cycle
            fetching <= 1'b1;
            drain    <= '0;
            ifid     <= '{pc: '0, instr: NOP_WORD};
        end else begin
            drain <= {drain[1:0], halt_seen};
            if (halt_seen)
                fetching <= 1'b0; // nothing younger than halt enters
            if (!stall) begin // stall freezes pc and if/id
                if (fetching && !halt_seen)
                    pc <= redirect ? redirect_pc : pc + 32'd4;
                if (!fetching || redirect || halt_seen)
                    ifid <= '{pc: '0, instr: NOP_WORD}; // squash
                else
                    ifid <= '{pc: pc, instr: fetch_word};
            end
        end
    end

    assign fetch_addr = pc;
    // busy until the halt has reached mem/wb, so older stores still count as running
    assign running = fetching | (|drain);

endmodule

// File: hdl/tinker_memory.sv
`timescale 1ns/100ps

module tinker_memory (
    input  logic                        clk,
    input  tinker_pkg::addr_t           fetch_addr,
    output logic [tinker_pkg::ILEN-1:0] fetch_word,
    input  tinker_pkg::addr_t           data_addr,
    input  logic                        data_we,
    input  logic [tinker_pkg::XLEN-1:0] store_data,
    output logic [tinker_pkg::XLEN-1:0] load_data,
    input  logic                        load_we,
    input  tinker_pkg::addr_t           load_addr,
    input  logic [tinker_pkg::ILEN-1:0] load_word,
    input  logic                        running,
    input  tinker_pkg::addr_t           peek_addr,
    output logic [tinker_pkg::XLEN-1:0] peek_data
);
    import tinker_pkg::*;

    logic [7:0]      mem [MEM_BYTES]; // byte array, contents undefined after reset
    logic [XLEN-1:0] fetch_raw;

    // little endian gather, wraps at the top of memory
    function automatic logic [XLEN-1:0] read_le(addr_t base, int unsigned nbytes);
        logic [XLEN-1:0] v;
        v = '0;
        for (int unsigned i = 0; i < nbytes; i++)
            v[8*i +: 8] = mem[(base + i) % MEM_BYTES];
        return v;
    endfunction

    always_comb begin
        fetch_raw = read_le(fetch_addr, 4);
        load_data = read_le(data_addr, 8);  // mem stage load
        peek_data = read_le(peek_addr, 8);  // debug port
    end

    assign fetch_word = fetch_raw[ILEN-1:0];

    always_ff @(posedge clk) begin
        if (data_we) begin // store from ex/mem
            for (int unsigned i = 0; i < 8; i++)
                mem[(data_addr + i) % MEM_BYTES] <= store_data[8*i +: 8];
        end
        // program load, only while idle
        if (load_we && !running) begin
            for (int unsigned i = 0; i < 4; i++)
                mem[(load_addr + i) % MEM_BYTES] <= load_word[8*i +: 8];
        end
    end

endmodule

// File: hdl/tinker_pkg.sv
package tinker_pkg;

    localparam int XLEN      = 64;   // data path width
    localparam int ILEN      = 32;   // instruction width
    localparam int REG_COUNT = 32;
    localparam int MEM_BYTES = 4096; // unified memory, addresses wrap

    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [31:0]                  addr_t;

    localparam addr_t           PC_RESET_ADDR = 32'h0000_0200;
    localparam logic [ILEN-1:0] NOP_WORD      = 32'h8800_0000; // mov r0,r0

    // tinker opcodes, bits 31..27 of the instruction
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08, // pc = rd
        OP_BRR_RD = 5'h09, // pc += rd
        OP_BRR_L  = 5'h0a, // pc += sext(L)
        OP_BRNZ   = 5'h0b,
        OP_BRGT   = 5'h0e,
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10, // mov rd,(rs)(L)
        OP_MOV_RR = 5'h11,
        OP_MOV_RL = 5'h12, // low 12 bits only
        OP_STORE  = 5'h13, // mov (rd)(L),rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    typedef struct packed {
        logic reg_write;     // rd written in wb
        logic mem_read;      // load
        logic mem_write;     // store
        logic mem_to_reg;    // wb takes memory data
        logic is_branch;
        logic halt;
        logic uses_imm_base; // rd is a source operand with L
    } ctrl_t;

    typedef struct packed {
        addr_t           pc;
        logic [ILEN-1:0] instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t           ctrl;
        opcode_t         opcode;
        reg_idx_t        rd;
        reg_idx_t        rs;
        reg_idx_t        rt;
        logic [11:0]     lit;
        addr_t           pc;
        logic [XLEN-1:0] rd_val;
        logic [XLEN-1:0] rs_val;
        logic [XLEN-1:0] rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_result; // also the data address
        logic [XLEN-1:0] store_data;
        reg_idx_t        dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] mem_data;
        logic [XLEN-1:0] alu_result;
        reg_idx_t        dest;
    } memwb_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_t;

endpackage

// File: hdl/tinker_regfile.sv
`timescale 1ns/100ps

module tinker_regfile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        we,
    input  tinker_pkg::reg_idx_t        wr_addr,
    input  logic [tinker_pkg::XLEN-1:0] wr_data,
    input  tinker_pkg::reg_idx_t        rd_addr,
    input  tinker_pkg::reg_idx_t        rs_addr,
    input  tinker_pkg::reg_idx_t        rt_addr,
    output logic [tinker_pkg::XLEN-1:0] rd_val,
    output logic [tinker_pkg::XLEN-1:0] rs_val,
    output logic [tinker_pkg::XLEN-1:0] rt_val
);
    import tinker_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write first: decode sees the wb value in the same cycle
    assign rd_val = (we && wr_addr == rd_addr) ? wr_data : regs[rd_addr];
    assign rs_val = (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_val = (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// File: hdl/tinker_writeback.sv
`timescale 1ns/100ps

module tinker_writeback (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  tinker_pkg::exmem_t          exmem,
    input  logic [tinker_pkg::XLEN-1:0] load_data,
    output tinker_pkg::reg_idx_t        wb_dest,
    output logic [tinker_pkg::XLEN-1:0] wb_data,
    output logic                        wb_we,
    output logic                        hlt
);
    import tinker_pkg::*;

    memwb_t memwb;
    logic   halted;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb  <= '0;
            halted <= 1'b0;
        end else begin
            memwb <= '{ctrl: exmem.ctrl, mem_data: load_data,
                       alu_result: exmem.alu_result, dest: exmem.dest};
            if (start)
                halted <= 1'b0;
            else if (memwb.ctrl.halt)
                halted <= 1'b1; // sticky until next start
        end
    end

    assign wb_dest = memwb.dest;
    assign wb_we   = memwb.ctrl.reg_write;
    assign wb_data = memwb.ctrl.mem_to_reg ? memwb.mem_data : memwb.alu_result;
    assign hlt     = halted;

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);
    localparam real HALF_PERIOD = 2.0; // 4 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb/tinker_assertions.sv
`timescale 1ns/100ps

module tinker_assertions (
    input logic               clk,
    input logic               reset,
    input logic               start,
    input logic               hlt,
    input logic               running,
    input tinker_pkg::exmem_t exmem
);
    logic started;      // a start seen since reset
    int   failures = 0; // failed assertions so far

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    // nothing has run yet so nothing can have halted
    hlt_low_before_start: assert property (
        @(posedge clk) disable iff (reset) !started |-> !hlt
    ) else begin
        $error("hlt high before the first start");
        failures++;
    end

    // sticky until the next start
    hlt_held: assert property (
        @(posedge clk) disable iff (reset) (hlt && !start) |=> hlt
    ) else begin
        $error("hlt dropped without a start");
        failures++;
    end

    idle_no_store: assert property (
        @(posedge clk) disable iff (reset) exmem.ctrl.mem_write |-> running
    ) else begin
        $error("memory store while the core is idle");
        failures++;
    end

endmodule

bind tinker_core tinker_assertions u_assertions (
    .clk, .reset, .start, .hlt, .running, .exmem
);

// File: tb/tinker_tb_tests.svh
    // dependent chain with every result stored at 0x800 and up
    task automatic arith_chain();
        int              a, b, c, d;
        int              s1, s2, s3;
        int              regs [10];
        logic [XLEN-1:0] r [14]; // expected register values
        a  = lfsr_bits(12);
        b  = lfsr_bits(12);
        c  = lfsr_bits(12);
        d  = lfsr_bits(12);
        s1 = lfsr_bits(6); // shift counts below 64
        s2 = lfsr_bits(6);
        s3 = lfsr_bits(6);
        prog.delete();
        set_reg(20, 'h800);
        set_reg(1, a);
        set_reg(2, b);
        emit(OP_ADD, 3, 1, 2, 0);  // r2 forwarded from ex/mem
        emit(OP_ADDI, 3, 0, 0, c);
        emit(OP_SUB, 4, 3, 1, 0);
        emit(OP_SUBI, 4, 0, 0, d);
        emit(OP_MUL, 5, 4, 3, 0);  // r3 through the write-first regfile
        emit(OP_AND, 6, 5, 3, 0);
        emit(OP_OR, 7, 6, 2, 0);
        emit(OP_XOR, 8, 7, 5, 0);
        emit(OP_NOT, 9, 8, 0, 0);
        set_reg(10, s1);
        emit(OP_SHFTR, 11, 9, 10, 0);
        emit(OP_SHFTL, 12, 11, 10, 0); // r10 forwarded from mem/wb
        emit(OP_SHFTRI, 12, 0, 0, s2);
        emit(OP_MOV_RR, 13, 12, 0, 0);
        emit(OP_SHFTLI, 13, 0, 0, s3);
        regs = '{3, 4, 5, 6, 7, 8, 9, 11, 12, 13};
        foreach (regs[i])
            emit(OP_STORE, 20, regs[i], 0, 8 * i); // store data is rs
        emit(OP_HALT, 0, 0, 0, 0);
        r[3]  = XLEN'(a) + XLEN'(b) + XLEN'(c);
        r[4]  = r[3] - XLEN'(a) - XLEN'(d); // may wrap below zero
        r[5]  = r[4] * r[3];
        r[6]  = r[5] & r[3];
        r[7]  = r[6] | XLEN'(b);
        r[8]  = r[7] ^ r[5];
        r[9]  = ~r[8];
        r[11] = r[9] >> s1;
        r[12] = (r[11] << s1) >> s2;
        r[13] = r[12] << s3;
        load_program();
        start_and_wait("arith_chain");
        foreach (regs[i])
            check_mem("arith_chain", 'h800 + 8 * i, r[regs[i]]);
    endtask

    // load result consumed by the very next instruction
    task automatic load_use();
        int              v;
        logic [XLEN-1:0] big;
        v   = lfsr_bits(12) | 1;
        big = XLEN'(v) << 20;
        prog.delete();
        set_reg(20, 'h900);
        set_reg(1, v);
        emit(OP_SHFTLI, 1, 0, 0, 20);
        emit(OP_STORE, 20, 1, 0, 0);
        emit(OP_LOAD, 2, 20, 0, 0);
        emit(OP_ADD, 3, 2, 1, 0);   // needs the stall
        emit(OP_STORE, 20, 3, 0, 8);
        emit(OP_LOAD, 4, 20, 0, 8);
        emit(OP_ADDI, 4, 0, 0, 5);  // load-use through rd
        emit(OP_STORE, 20, 4, 0, 16);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        start_and_wait("load_use");
        check_mem("load_use", 'h900, big);
        check_mem("load_use", 'h908, 2 * big);
        check_mem("load_use", 'h910, 2 * big + 5);
    endtask

    // countdown with brnz, brgt skip, brr L and br over dead stores
    task automatic branch_loop();
        int              n, k;
        int              loop_at, skip_at, end_at;
        logic [XLEN-1:0] sum;
        n       = lfsr_bits(4) + 1; // 1..16 passes
        k       = lfsr_bits(4);
        loop_at = PC_RESET_ADDR + 4 * 14;
        skip_at = PC_RESET_ADDR + 4 * 17;
        end_at  = PC_RESET_ADDR + 4 * 25;
        sum     = '0;
        for (int cnt = n; cnt > 0; cnt--)
            sum += (cnt > k) ? cnt : cnt + 'h100; // bonus when not greater
        for (int i = 0; i < 4; i++)
            write_dword('hA00 + 8 * i, sentinel('hA00 + 8 * i));
        prog.delete();
        set_reg(20, 'hA00);
        set_reg(1, n);       // counter
        set_reg(2, 0);       // sum
        set_reg(5, loop_at);
        set_reg(6, skip_at);
        set_reg(7, k);
        set_reg(8, end_at);
        emit(OP_ADD, 2, 2, 1, 0);    // loop_at
        emit(OP_BRGT, 6, 1, 7, 0);
        emit(OP_ADDI, 2, 0, 0, 'h100);
        emit(OP_SUBI, 1, 0, 0, 1);   // skip_at
        emit(OP_BRNZ, 5, 1, 0, 0);   // branch stalls while r1 is in flight
        emit(OP_BRR_L, 0, 0, 0, 8);
        emit(OP_STORE, 20, 2, 0, 'h10);
        emit(OP_STORE, 20, 1, 0, 0);
        emit(OP_STORE, 20, 2, 0, 8);
        emit(OP_BR, 8, 0, 0, 0);
        emit(OP_STORE, 20, 2, 0, 'h18);
        emit(OP_HALT, 0, 0, 0, 0);   // end_at
        load_program();
        start_and_wait("branch_loop");
        check_mem("branch_loop", 'hA00, '0);
        check_mem("branch_loop", 'hA08, sum);
        check_mem("branch_loop", 'hA10, sentinel('hA10));
        check_mem("branch_loop", 'hA18, sentinel('hA18));
    endtask

    task automatic halt_fence();
        int v;
        int drops;
        v = lfsr_bits(12) | 1;
        for (int i = 0; i < 3; i++)
            write_dword('hB00 + 8 * i, sentinel('hB00 + 8 * i));
        prog.delete();
        set_reg(20, 'hB00);
        set_reg(1, v);
        emit(OP_STORE, 20, 1, 0, 0); // older than halt so it commits
        emit(OP_HALT, 0, 0, 0, 0);
        emit(OP_STORE, 20, 1, 0, 8); // younger than halt and never runs
        emit(OP_STORE, 20, 1, 0, 16);
        load_program();
        start_and_wait("halt_fence");
        drops = 0;
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (!hlt)
                drops++;
        end
        checks++;
        if (drops != 0) begin
            $display("Error: halt_fence hlt low cycles expected 0 actual %0d", drops);
            errors++;
        end
        check_mem("halt_fence", 'hB00, XLEN'(v));
        check_mem("halt_fence", 'hB08, sentinel('hB08));
        check_mem("halt_fence", 'hB10, sentinel('hB10));
    endtask

    // mov rd,L keeps bits 63..12 and the program runs twice
    task automatic restart_movl();
        int              hi, lo, lo2;
        logic [XLEN-1:0] exp1, exp2;
        hi          = lfsr_bits(12) | 'h800;
        lo          = lfsr_bits(12);
        lo2         = lfsr_bits(12);
        exp1        = XLEN'(hi) << 8;
        exp1[11:0]  = lo[11:0];
        exp2        = '1;
        exp2[11:0]  = lo2[11:0];
        prog.delete();
        set_reg(20, 'hC00);
        set_reg(1, hi);
        emit(OP_SHFTLI, 1, 0, 0, 8);  // bits 8..19 now set
        emit(OP_MOV_RL, 1, 0, 0, lo);
        emit(OP_STORE, 20, 1, 0, 0);
        emit(OP_XOR, 3, 3, 3, 0);
        emit(OP_NOT, 3, 3, 0, 0);     // all ones
        emit(OP_MOV_RL, 3, 0, 0, lo2);
        emit(OP_STORE, 20, 3, 0, 8);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        for (int pass = 0; pass < 2; pass++) begin
            write_dword('hC00, sentinel('hC00)); // wipe last results
            write_dword('hC08, sentinel('hC08));
            start_and_wait("restart_movl");
            check_mem("restart_movl", 'hC00, exp1);
            check_mem("restart_movl", 'hC08, exp2);
        end
    endtask

// File: tb/tinker_tb.sv
`timescale 1ns/100ps

module tinker_tb;
    import tinker_pkg::*;

    localparam int          HALT_TIMEOUT = 2000;          // cycles per run
    localparam int          RESET_LIMIT  = 20;
    localparam logic [31:0] LFSR_SEED    = 32'hd52f;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003; // x^32+x^22+x^2+x+1

    logic            clk;
    logic            reset;
    logic            start;
    logic            load_we;
    addr_t           load_addr;
    logic [ILEN-1:0] load_word;
    addr_t           peek_addr;
    logic [XLEN-1:0] peek_data;
    logic            hlt;

    logic [31:0]     lfsr_state;
    logic [ILEN-1:0] prog [$]; // program under assembly with word 0 at PC_RESET_ADDR
    int              errors;
    int              checks;

    clock_gen u_clock (
        .clk,
        .reset
    );

    tinker_core u_dut (
        .clk, .reset, .start, .load_we, .load_addr, .load_word,
        .peek_addr, .peek_data, .hlt
    );

    // galois lfsr with one shift per bit taken
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // opcode | rd | rs | rt | L
    function automatic logic [ILEN-1:0] encode(opcode_t op, int rd, int rs, int rt, int lit);
        return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
    endfunction

    function automatic void emit(opcode_t op, int rd, int rs, int rt, int lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endfunction

    // clear then set the low 12 bits
    function automatic void set_reg(int r, int val);
        emit(OP_XOR, r, r, r, 0);
        emit(OP_MOV_RL, r, 0, 0, val);
    endfunction

    // marker for words that must stay untouched
    function automatic logic [XLEN-1:0] sentinel(addr_t addr);
        return {~addr, addr ^ 32'h3c3c_0000};
    endfunction

    task automatic write_word(addr_t addr, logic [31:0] word);
        @(posedge clk);
        load_we   <= 1'b1;
        load_addr <= addr;
        load_word <= word;
        @(posedge clk);
        load_we   <= 1'b0;
    endtask

    task automatic write_dword(addr_t addr, logic [XLEN-1:0] v);
        write_word(addr, v[31:0]); // little endian
        write_word(addr + 4, v[63:32]);
    endtask

    task automatic load_program();
        foreach (prog[i])
            write_word(PC_RESET_ADDR + 4 * i, prog[i]);
    endtask

    task automatic start_and_wait(string name);
        int n;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checks++;
        if (hlt) begin // start clears the halted flag
            $display("Error: %s hlt after start expected 0 actual 1", name);
            errors++;
        end
        n = 0;
        while (!hlt && n < HALT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!hlt) begin
            $display("%s did not halt within %0d cycles", name, HALT_TIMEOUT);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_mem(string name, addr_t addr, logic [XLEN-1:0] expected);
        @(posedge clk);
        peek_addr <= addr;
        @(negedge clk); // peek is combinational
        checks++;
        if (peek_data !== expected) begin
            $display("Error: %s at 0x%03h expected 0x%016h actual 0x%016h",
                     name, addr, expected, peek_data);
            errors++;
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset && n < RESET_LIMIT);
        if (reset) begin
            $display("reset was never released");
            errors++;
            finish_run();
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = u_dut.u_assertions.failures;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, asserts);
        if (errors == 0 && asserts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    `include "tinker_tb_tests.svh"

    initial begin
        start      = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_word  = '0;
        peek_addr  = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = LFSR_SEED;
        wait_reset();
        arith_chain();
        load_use();
        branch_loop();
        halt_fence();
        restart_movl();
        finish_run();
    end

endmodule

// File: tinker.f
+incdir+tb
hdl/tinker_pkg.sv
hdl/tinker_regfile.sv
hdl/tinker_memory.sv
hdl/tinker_fetch.sv
hdl/tinker_decode.sv
hdl/tinker_execute.sv
hdl/tinker_writeback.sv
hdl/tinker_core.sv
tb/clock_gen.sv
tb/tinker_assertions.sv
tb/tinker_tb.sv
